//--- sim/cast_cases.txt
// op(0 I2F, 1 F2I) op_mod(1 unsigned) rnd_mode(frm) operand result status(NV DZ OF UF NX), hex
// Exact conversions
0 0 0 00000001 3F800000 00
0 0 0 FFFFFFFF BF800000 00
0 0 0 00000000 00000000 00
0 0 1 80000000 CF000000 00
1 0 0 42F60000 0000007B 00
1 0 0 C2F60000 FFFFFF85 00
1 1 0 4F000000 80000000 00
1 0 0 CF000000 80000000 00
// Rounding in all five modes
0 0 0 01000001 4B800000 01
0 0 1 01000001 4B800000 01
0 0 2 01000001 4B800000 01
0 0 3 01000001 4B800001 01
0 0 4 01000001 4B800001 01
0 0 0 01000003 4B800002 01
0 0 2 FEFFFFFF CB800001 01
0 1 0 FFFFFFFF 4F800000 01
1 0 0 40200000 00000002 01
1 0 1 40200000 00000002 01
1 0 2 40200000 00000002 01
1 0 3 40200000 00000003 01
1 0 4 40200000 00000003 01
1 0 2 C0200000 FFFFFFFD 01
1 0 4 C0200000 FFFFFFFD 01
1 0 0 40600000 00000004 01
// Invalid F2I cases saturate
1 0 0 7FC00000 7FFFFFFF 10
1 1 0 7FC00000 FFFFFFFF 10
1 0 0 FF800000 80000000 10
1 1 0 FF800000 00000000 10
1 0 0 4F32D05E 7FFFFFFF 10
1 1 0 BF800000 00000000 10
1 1 1 BF000000 00000000 01
// Zero and subnormal inputs
1 0 0 00000000 00000000 00
1 0 0 00000001 00000000 01
1 0 3 00000001 00000001 01
1 0 2 80000001 FFFFFFFF 01

//--- all.f
hdl/cast_pkg.sv
hdl/cast_classify.sv
hdl/cast_normalize.sv
hdl/cast_round.sv
hdl/cast_result.sv
hdl/cast_pipe_reg.sv
hdl/cast_unit.sv
sim/cast_checker.sv
sim/cast_tb.sv

//--- Bender.yml
package:
  name: cast_unit

sources:
  - hdl/cast_pkg.sv
  - hdl/cast_classify.sv
  - hdl/cast_normalize.sv
  - hdl/cast_round.sv
  - hdl/cast_result.sv
  - hdl/cast_pipe_reg.sv
  - hdl/cast_unit.sv
  - target: simulation
    files:
      - sim/cast_checker.sv
      - sim/cast_tb.sv

//--- sim/cast_tb.sv
// Feeds every case of sim/cast_cases.txt with random input gaps and output stalls, seed 66
`timescale 1ns/10ps
`default_nettype none

module cast_tb;

  import cast_pkg::*;

  localparam int unsigned MAX_CASES = 64;
  localparam int unsigned FIELDS    = 6;
  localparam time         PERIOD    = 20;

  logic                  clk;
  logic                  arst_n;
  logic                  flush;
  logic                  in_valid;
  logic                  in_ready;
  logic [DATA_WIDTH-1:0] operand;
  op_e                   op;
  logic                  op_mod;
  round_e                rnd_mode;
  logic                  out_valid;
  logic                  out_ready;
  logic [DATA_WIDTH-1:0] result;
  status_t               status;
  logic                  busy;
  logic                  report;
  int                    tb_errors;
  int                    checked;
  int                    chk_errors;
  int                    n_cases;
  logic [DATA_WIDTH-1:0] cases [FIELDS*MAX_CASES];

  initial begin : clock_gen
    clk = 1'b0;
    forever #(PERIOD/2) clk = ~clk;
  end

  cast_unit dut_i (
    .clk_i       ( clk       ),
    .arst_n_i    ( arst_n    ),
    .flush_i     ( flush     ),
    .in_valid_i  ( in_valid  ),
    .in_ready_o  ( in_ready  ),
    .operand_i   ( operand   ),
    .op_i        ( op        ),
    .op_mod_i    ( op_mod    ),
    .rnd_mode_i  ( rnd_mode  ),
    .out_valid_o ( out_valid ),
    .out_ready_i ( out_ready ),
    .result_o    ( result    ),
    .status_o    ( status    ),
    .busy_o      ( busy      )
  );

  cast_checker #(.MAX_CASES(MAX_CASES)) u_checker (
    .clk_i       ( clk        ),
    .arst_n_i    ( arst_n     ),
    .out_valid_i ( out_valid  ),
    .out_ready_i ( out_ready  ),
    .result_i    ( result     ),
    .status_i    ( status     ),
    .report_i    ( report     ),
    .tb_errors_i ( tb_errors  ),
    .checked_o   ( checked    ),
    .errors_o    ( chk_errors )
  );

  // --------------------------------------------------------------------
  // Stimulus helpers
  // --------------------------------------------------------------------
  task automatic drive_case(input int idx);
    int base;
    base     = FIELDS * idx;
    op       = op_e'(cases[base][0]);
    op_mod   = cases[base+1][0];
    rnd_mode = round_e'(cases[base+2][2:0]);
    operand  = cases[base+3];
    in_valid = 1'b1;
    do begin
      @(posedge clk);  // Ready sampled before the edge updates
    end while (!in_ready);
    @(negedge clk);
    in_valid = 1'b0;
  endtask

  task automatic stall_out_ready();
    wait (checked != 0);  // First result goes out unstalled
    forever begin
      @(negedge clk);
      out_ready = ($urandom_range(3) != 0);  // Roughly one stall in four
    end
  endtask

  initial begin : main
    int gap;
    void'($urandom(66));
    arst_n    = 1'b0;
    flush     = 1'b0;
    in_valid  = 1'b0;
    operand   = '0;
    op        = OP_I2F;
    op_mod    = 1'b0;
    rnd_mode  = RM_RNE;
    out_ready = 1'b1;
    report    = 1'b0;
    tb_errors = 0;
    $readmemh("sim/cast_cases.txt", cases);
    n_cases = 0;
    while (n_cases < MAX_CASES && !$isunknown(cases[FIELDS*n_cases])) n_cases++;
    repeat (4) @(negedge clk);
    // Empty pipeline ready to accept out of reset
    if (!in_ready || out_valid || busy) begin
      $display("Error at %0d ns: in_ready_o %b out_valid_o %b busy_o %b after reset", $time,
               in_ready, out_valid, busy);
      tb_errors++;
    end
    arst_n = 1'b1;
    fork
      stall_out_ready();
    join_none
    for (int i = 0; i < n_cases; i++) begin
      gap = (i == 0) ? 0 : $urandom_range(2);
      repeat (gap) @(negedge clk);
      drive_case(i);
    end
    wait (checked >= n_cases);
    @(negedge clk);
    if (busy || out_valid) begin
      $display("Error at %0d ns: busy_o or out_valid_o still high after the last result", $time);
      tb_errors++;
    end
    report = 1'b1;
    #1;
    if (chk_errors == 0 && tb_errors == 0 && checked == n_cases && n_cases > 0) begin
      $display("All tests passed");
    end else begin
      $display("Some tests failed");
    end
    $finish;
  end

  // First item with no stall leaves exactly two edges after acceptance
  initial begin : latency_check
    @(posedge arst_n);
    do begin
      @(posedge clk);
    end while (!(in_valid && in_ready));
    @(posedge clk);
    if (out_valid) begin
      $display("Error at %0d ns: first result showed up after one cycle", $time);
      tb_errors++;
    end
    if (!busy) begin
      $display("Error at %0d ns: busy_o low while an item is in flight", $time);
      tb_errors++;
    end
    @(posedge clk);
    if (!out_valid) begin
      $display("Error at %0d ns: first result missing two cycles after acceptance", $time);
      tb_errors++;
    end
  end

  initial begin : watchdog
    @(posedge arst_n);
    #(PERIOD * (40 * n_cases + 100));
    $display("Timeout: the DUT stopped delivering results, %0d of %0d seen", checked, n_cases);
    $display("Some tests failed");
    $finish;
  end

endmodule

`default_nettype wire

//--- sim/cast_checker.sv
// Checks output transfers in case-file order, the case file path is relative to the project root
`timescale 1ns/10ps
`default_nettype none

module cast_checker #(
  parameter int unsigned MAX_CASES = 64
) (
  input  logic                            clk_i,
  input  logic                            arst_n_i,
  input  logic                            out_valid_i,
  input  logic                            out_ready_i,
  input  logic [cast_pkg::DATA_WIDTH-1:0] result_i,
  input  cast_pkg::status_t               status_i,
  input  logic                            report_i,     // Rising edge prints the counts
  input  int                              tb_errors_i,
  output int                              checked_o,
  output int                              errors_o
);

  import cast_pkg::*;

  localparam int unsigned FIELDS = 6;  // op, op_mod, rnd_mode, operand, result, status

  logic [DATA_WIDTH-1:0] cases [FIELDS*MAX_CASES];
  int                    n_cases;
  int                    chk_cnt = 0;
  int                    err_cnt = 0;
  logic                  held = 1'b0;  // Stalled item seen at the last edge
  logic [DATA_WIDTH-1:0] held_result;
  status_t               held_status;

  initial begin : load_cases
    $readmemh("sim/cast_cases.txt", cases);
    n_cases = 0;
    while (n_cases < MAX_CASES && !$isunknown(cases[FIELDS*n_cases])) n_cases++;
  end

  // --------------------------------------------------------------------
  // Output side, sampled at the transfer edge
  // --------------------------------------------------------------------
  always @(posedge clk_i) begin : compare
    int base;
    if (arst_n_i) begin
      // A stalled item must stay put until it is taken
      if (held && !(out_valid_i && result_i === held_result && status_i === held_status)) begin
        $display("Error at %0d ns: stalled output changed before it was taken", $time);
        err_cnt++;
      end
      if (out_valid_i && out_ready_i) begin
        if (chk_cnt >= n_cases) begin
          $display("Error at %0d ns: result %h arrived after the last case", $time, result_i);
          err_cnt++;
        end else begin
          base = FIELDS * chk_cnt;
          if (result_i !== cases[base+4]) begin
            $display("Error at %0d ns: case %0d (%0h %0h %0h %h) result %h, expected %h",
                     $time, chk_cnt, cases[base], cases[base+1], cases[base+2], cases[base+3],
                     result_i, cases[base+4]);
            err_cnt++;
          end
          if (status_i !== cases[base+5][4:0]) begin
            $display("Error at %0d ns: case %0d (operand %h) status %h, expected %h",
                     $time, chk_cnt, cases[base+3], status_i, cases[base+5][4:0]);
            err_cnt++;
          end
        end
        chk_cnt++;
      end
      held        = out_valid_i && !out_ready_i;
      held_result = result_i;
      held_status = status_i;
    end
  end

  always @(posedge report_i) begin : closing_line
    $display("Cases %0d, results checked %0d, checker errors %0d, testbench errors %0d",
             n_cases, chk_cnt, err_cnt, tb_errors_i);
  end

  assign checked_o = chk_cnt;
  assign errors_o  = err_cnt;

endmodule

`default_nettype wire

//--- hdl/cast_unit.sv
// Binary32 to int32 caster and back, two cycles of latency, flush drops both stages
`timescale 1ns/10ps
`default_nettype none

module cast_unit (
  input  logic                            clk_i,
  input  logic                            arst_n_i,
  input  logic                            flush_i,
  input  logic                            in_valid_i,
  output logic                            in_ready_o,
  input  logic [cast_pkg::DATA_WIDTH-1:0] operand_i,
  input  cast_pkg::op_e                   op_i,
  input  logic                            op_mod_i,    // 1 selects unsigned integer
  input  cast_pkg::round_e                rnd_mode_i,
  output logic                            out_valid_o,
  input  logic                            out_ready_i,
  output logic [cast_pkg::DATA_WIDTH-1:0] result_o,
  output cast_pkg::status_t               status_o,
  output logic                            busy_o
);

  import cast_pkg::*;

  // Front end
  class_t                      in_class;
  logic                        in_sign;
  logic                        in_mant_zero;
  logic signed [EXP_WIDTH-1:0] in_exp;
  logic signed [EXP_WIDTH-1:0] in_dst_exp;
  logic [MANT_WIDTH-1:0]       in_mant;

  // Stage 1 payload
  logic [STAGE1_WIDTH-1:0]     s1_data_in;
  logic [STAGE1_WIDTH-1:0]     s1_data;
  logic                        s1_valid;
  class_t                      s1_class;
  logic                        s1_sign;
  logic                        s1_mant_zero;
  logic                        s1_op_mod;
  logic signed [EXP_WIDTH-1:0] s1_exp;
  logic signed [EXP_WIDTH-1:0] s1_dst_exp;
  logic [MANT_WIDTH-1:0]       s1_mant;
  logic [$bits(op_e)-1:0]      s1_op;
  logic [$bits(round_e)-1:0]   s1_rnd;

  // Back end
  logic [DATA_WIDTH-1:0]       rounded;
  logic [DATA_WIDTH-1:0]       result;
  logic                        of_before;
  logic                        uf_before;
  logic                        inexact;
  status_t                     status;
  logic                        s2_ready;
  logic [STAGE2_WIDTH-1:0]     s2_data;

  // --------------------------------------------------------------------
  // Classification and normalization
  // --------------------------------------------------------------------
  cast_classify u_classify (
    .operand_i ( operand_i ),
    .class_o   ( in_class  )
  );

  cast_normalize u_normalize (
    .operand_i   ( operand_i    ),
    .op_i        ( op_i         ),
    .op_mod_i    ( op_mod_i     ),
    .class_i     ( in_class     ),
    .sign_o      ( in_sign      ),
    .exp_o       ( in_exp       ),
    .dst_exp_o   ( in_dst_exp   ),
    .mant_o      ( in_mant      ),
    .mant_zero_o ( in_mant_zero )
  );

  assign s1_data_in = {in_sign, in_exp, in_dst_exp, in_mant, in_mant_zero, in_class,
                       op_i, op_mod_i, rnd_mode_i};

  cast_pipe_reg #(.WIDTH(STAGE1_WIDTH)) u_stage1 (
    .clk_i    ( clk_i      ),
    .arst_n_i ( arst_n_i   ),
    .flush_i  ( flush_i    ),
    .valid_i  ( in_valid_i ),
    .ready_o  ( in_ready_o ),
    .data_i   ( s1_data_in ),
    .valid_o  ( s1_valid   ),
    .ready_i  ( s2_ready   ),  // Combinational ready from stage 2
    .data_o   ( s1_data    )
  );

  assign {s1_sign, s1_exp, s1_dst_exp, s1_mant, s1_mant_zero, s1_class,
          s1_op, s1_op_mod, s1_rnd} = s1_data;

  // --------------------------------------------------------------------
  // Rounding and result
  // --------------------------------------------------------------------
  cast_round u_round (
    .op_i        ( op_e'(s1_op)     ),
    .op_mod_i    ( s1_op_mod        ),
    .rnd_mode_i  ( round_e'(s1_rnd) ),
    .sign_i      ( s1_sign          ),
    .exp_i       ( s1_exp           ),
    .dst_exp_i   ( s1_dst_exp       ),
    .mant_i      ( s1_mant          ),
    .class_i     ( s1_class         ),
    .rounded_o   ( rounded          ),
    .of_before_o ( of_before        ),
    .uf_before_o ( uf_before        ),
    .inexact_o   ( inexact          )
  );

  cast_result u_result (
    .op_i        ( op_e'(s1_op) ),
    .op_mod_i    ( s1_op_mod    ),
    .sign_i      ( s1_sign      ),
    .class_i     ( s1_class     ),
    .mant_zero_i ( s1_mant_zero ),
    .rounded_i   ( rounded      ),
    .of_before_i ( of_before    ),
    .uf_before_i ( uf_before    ),
    .inexact_i   ( inexact      ),
    .result_o    ( result       ),
    .status_o    ( status       )
  );

  cast_pipe_reg #(.WIDTH(STAGE2_WIDTH)) u_stage2 (
    .clk_i    ( clk_i            ),
    .arst_n_i ( arst_n_i         ),
    .flush_i  ( flush_i          ),
    .valid_i  ( s1_valid         ),
    .ready_o  ( s2_ready         ),
    .data_i   ( {result, status} ),
    .valid_o  ( out_valid_o      ),
    .ready_i  ( out_ready_i      ),
    .data_o   ( s2_data          )
  );

  assign {result_o, status_o} = s2_data;
  assign busy_o = s1_valid | out_valid_o;  // Anything in flight

endmodule

`default_nettype wire

//--- hdl/cast_pipe_reg.sv
// One-slot elastic stage, ready_o is combinational on ready_i so chains form one ready path
`timescale 1ns/10ps
`default_nettype none

module cast_pipe_reg #(
  parameter int unsigned WIDTH = 32
) (
  input  logic             clk_i,
  input  logic             arst_n_i,
  input  logic             flush_i,    // Drops the held item
  input  logic             valid_i,
  output logic             ready_o,
  input  logic [WIDTH-1:0] data_i,
  output logic             valid_o,
  input  logic             ready_i,
  output logic [WIDTH-1:0] data_o
);

  logic             valid_q;
  logic             load;
  logic [WIDTH-1:0] data_q;

  // Advance when downstream takes the item or the slot only holds a bubble
  assign ready_o = ready_i | ~valid_q;
  assign load    = ready_o & valid_i;  // Payload moves only with a real item

  always_ff @(posedge clk_i or negedge arst_n_i) begin : valid_reg
    if (!arst_n_i) begin
      valid_q <= 1'b0;
    end else if (flush_i) begin
      valid_q <= 1'b0;
    end else if (ready_o) begin
      valid_q <= valid_i;
    end
  end

  always_ff @(posedge clk_i) begin : data_reg
    if (load) begin
      data_q <= data_i;
    end
  end

  assign valid_o = valid_q;
  assign data_o  = data_q;

  // A stalled item stays until taken or flushed
  assert property (@(posedge clk_i) disable iff (!arst_n_i)
    valid_o && !ready_i && !flush_i |=> valid_o && $stable(data_o))
    else $error("cast_pipe_reg: stalled item changed");

endmodule

`default_nettype wire

//--- hdl/cast_result.sv
// Zero-delay result select, the op picks float or integer destination
`timescale 1ns/10ps
`default_nettype none

module cast_result (
  input  cast_pkg::op_e                   op_i,
  input  logic                            op_mod_i,
  input  logic                            sign_i,
  input  cast_pkg::class_t                class_i,
  input  logic                            mant_zero_i,
  input  logic [cast_pkg::DATA_WIDTH-1:0] rounded_i,
  input  logic                            of_before_i,
  input  logic                            uf_before_i,
  input  logic                            inexact_i,
  output logic [cast_pkg::DATA_WIDTH-1:0] result_o,
  output cast_pkg::status_t               status_o
);

  import cast_pkg::*;

  logic                  src_is_int;
  logic                  of_after;
  logic                  uf_after;
  logic                  fp_special;
  logic                  int_special;
  logic                  int_zero;
  logic [DATA_WIDTH-1:0] fp_res;
  logic [DATA_WIDTH-1:0] fp_spec_res;
  logic [DATA_WIDTH-1:0] int_res;
  logic [DATA_WIDTH-1:0] int_spec_res;
  status_t               fp_status;
  status_t               int_status;

  assign src_is_int = (op_i == OP_I2F);

  // Exponent field after rounding
  assign of_after = (rounded_i[MAN_BITS +: EXP_BITS] == '1);
  assign uf_after = (rounded_i[MAN_BITS +: EXP_BITS] == '0);

  // Float destination, integer zero becomes +0.0
  assign fp_res      = {sign_i, rounded_i[DATA_WIDTH-2:0]};
  assign fp_special  = src_is_int ? mant_zero_i : (class_i.is_zero | class_i.is_nan);
  assign fp_spec_res = (src_is_int | class_i.is_zero) ? {sign_i, {(DATA_WIDTH-1){1'b0}}} : QNAN;

  // Integer destination
  assign int_res     = sign_i ? DATA_WIDTH'(-rounded_i) : rounded_i;  // Two's complement
  assign int_zero    = (int_res == '0);
  assign int_special = class_i.is_nan | class_i.is_inf | of_before_i
                     | (sign_i & op_mod_i & ~int_zero);               // Negative into unsigned

  always_comb begin : int_saturation
    int_spec_res = {op_mod_i, {(DATA_WIDTH-1){1'b1}}};  // Positive maximum
    // NaN sign is ignored
    if (sign_i && !class_i.is_nan) int_spec_res = ~int_spec_res;
  end

  always_comb begin : build_status
    fp_status  = '0;
    int_status = '0;
    if (fp_special) begin
      fp_status.NV = ~src_is_int & class_i.is_signalling;
    end else begin
      fp_status.NV = src_is_int & (of_before_i | of_after);
      fp_status.OF = ~src_is_int & ~class_i.is_inf & (of_before_i | of_after);
      fp_status.NX = inexact_i | fp_status.OF;
      fp_status.UF = (uf_before_i | uf_after) & fp_status.NX;  // Tiny and inexact
    end
    if (int_special) begin
      int_status.NV = 1'b1;                                     // Saturation is invalid
    end else begin
      int_status.NX = inexact_i;
    end
  end

  assign result_o = (op_i == OP_F2I) ? (int_special ? int_spec_res : int_res)
                                     : (fp_special ? fp_spec_res : fp_res);
  assign status_o = (op_i == OP_F2I) ? int_status : fp_status;

endmodule

`default_nettype wire

//--- hdl/cast_round.sv
// Zero-delay rounding, F2I gives an unsigned magnitude and I2F gives the float without sign
`timescale 1ns/10ps
`default_nettype none

module cast_round (
  input  cast_pkg::op_e                         op_i,
  input  logic                                  op_mod_i,
  input  cast_pkg::round_e                      rnd_mode_i,
  input  logic                                  sign_i,
  input  logic signed [cast_pkg::EXP_WIDTH-1:0] exp_i,
  input  logic signed [cast_pkg::EXP_WIDTH-1:0] dst_exp_i,
  input  logic [cast_pkg::MANT_WIDTH-1:0]       mant_i,
  input  cast_pkg::class_t                      class_i,
  output logic [cast_pkg::DATA_WIDTH-1:0]       rounded_o,
  output logic                                  of_before_o,
  output logic                                  uf_before_o,
  output logic                                  inexact_o
);

  import cast_pkg::*;

  logic                    dst_is_int;
  logic                    int_min;        // Exactly -2**31 into signed
  logic [EXP_WIDTH-1:0]    final_exp;
  logic [PRE_WIDTH-1:0]    preshift_mant;
  logic [PRE_WIDTH-1:0]    dest_mant;
  logic [DENORM_WIDTH-1:0] denorm_shamt;
  logic [MAN_BITS-1:0]     final_mant;
  logic [DATA_WIDTH-1:0]   final_int;
  logic [DATA_WIDTH-1:0]   pre_abs;
  logic [1:0]              fp_rs;          // Round and sticky per destination
  logic [1:0]              int_rs;
  logic [1:0]              rs;
  logic                    round_up;

  assign dst_is_int = (op_i == OP_F2I);
  assign int_min    = sign_i & ~op_mod_i & (exp_i == EXP_WIDTH'(DATA_WIDTH - 1))
                      & (mant_i[MANT_WIDTH-2:0] == '0);

  // --------------------------------------------------------------------
  // Shift amount and early range checks
  // --------------------------------------------------------------------
  always_comb begin : shift_amount
    final_exp     = unsigned'(dst_exp_i);
    preshift_mant = {mant_i, {(MANT_WIDTH + 1){1'b0}}}; // Mantissa at the top of the shifter
    denorm_shamt  = '0;
    of_before_o   = 1'b0;
    uf_before_o   = 1'b0;
    if (dst_is_int) begin
      denorm_shamt = DENORM_WIDTH'(int'(DATA_WIDTH) - 1 - int'(exp_i)); // Integer LSB in place
      // Unsigned range is one bit wider
      if (class_i.is_nan || class_i.is_inf ||
          (exp_i >= int'(DATA_WIDTH) - 1 + int'(op_mod_i) && !int_min)) begin
        denorm_shamt = '0;
        of_before_o  = 1'b1;
      end else if (exp_i < -1) begin
        denorm_shamt = DENORM_WIDTH'(DATA_WIDTH + 1);  // All bits into sticky
        uf_before_o  = 1'b1;
      end
    end else begin
      if (dst_exp_i >= int'(2**EXP_BITS) - 1) begin
        final_exp     = EXP_WIDTH'(2**EXP_BITS - 2);  // Largest normal with R and S set
        preshift_mant = '1;
        of_before_o   = 1'b1;
      end else if (dst_exp_i < 1 && dst_exp_i >= -int'(MAN_BITS)) begin
        final_exp    = '0;                             // Subnormal result
        denorm_shamt = DENORM_WIDTH'(1 - int'(dst_exp_i));
        uf_before_o  = 1'b1;
      end else if (dst_exp_i < -int'(MAN_BITS)) begin
        final_exp    = '0;
        denorm_shamt = DENORM_WIDTH'(MAN_BITS + 2);    // Keep only the sticky
        uf_before_o  = 1'b1;
      end
    end
  end

  // --------------------------------------------------------------------
  // Alignment and rounding
  // --------------------------------------------------------------------
  assign dest_mant = preshift_mant >> denorm_shamt;
  assign {final_mant, fp_rs[1]} = dest_mant[PRE_WIDTH-2 -: MAN_BITS+1];  // Hidden bit dropped
  assign {final_int, int_rs[1]} = dest_mant[PRE_WIDTH-1 -: DATA_WIDTH+1];
  assign fp_rs[0]  = |dest_mant[FP_STICKY-1:0];
  assign int_rs[0] = |dest_mant[INT_STICKY-1:0];

  assign rs      = dst_is_int ? int_rs : fp_rs;
  assign pre_abs = dst_is_int ? final_int : DATA_WIDTH'({final_exp[EXP_BITS-1:0], final_mant});

  always_comb begin : round_decision
    case (rnd_mode_i)
      RM_RNE:  round_up = rs[1] & (rs[0] | pre_abs[0]);  // Ties to even
      RM_RTZ:  round_up = 1'b0;
      RM_RDN:  round_up = (|rs) & sign_i;
      RM_RUP:  round_up = (|rs) & ~sign_i;
      RM_RMM:  round_up = rs[1];                          // Ties away from zero
      default: round_up = 1'b0;
    endcase
  end

  // Carry may ripple into the exponent field
  assign rounded_o = pre_abs + DATA_WIDTH'(round_up);
  assign inexact_o = |rs;

endmodule

`default_nettype wire

//--- hdl/cast_normalize.sv
// Zero-delay front end, a zero source gives a zero mantissa and a meaningless exponent
`timescale 1ns/10ps
`default_nettype none

module cast_normalize (
  input  logic [cast_pkg::DATA_WIDTH-1:0]       operand_i,
  input  cast_pkg::op_e                         op_i,
  input  logic                                  op_mod_i,    // 1 selects unsigned integer
  input  cast_pkg::class_t                      class_i,
  output logic                                  sign_o,
  output logic signed [cast_pkg::EXP_WIDTH-1:0] exp_o,       // Unbiased
  output logic signed [cast_pkg::EXP_WIDTH-1:0] dst_exp_o,   // Rebiased for binary32
  output logic [cast_pkg::MANT_WIDTH-1:0]       mant_o,
  output logic                                  mant_zero_o
);

  import cast_pkg::*;

  logic                        src_is_int;
  logic                        int_sign;
  logic [MANT_WIDTH-1:0]       int_mant;
  logic [MANT_WIDTH-1:0]       fp_mant;
  logic [MANT_WIDTH-1:0]       enc_mant;
  logic [SHAMT_WIDTH-1:0]      lz_cnt;
  logic signed [EXP_WIDTH-1:0] fp_exp;
  logic signed [EXP_WIDTH-1:0] int_exp;

  assign src_is_int = (op_i == OP_I2F);

  // Integer source as magnitude
  assign int_sign = operand_i[DATA_WIDTH-1] & ~op_mod_i;  // Unsigned never negative
  assign int_mant = int_sign ? MANT_WIDTH'(-operand_i) : MANT_WIDTH'(operand_i);

  // Float source, hidden bit only for normals
  assign fp_mant  = MANT_WIDTH'({class_i.is_normal, operand_i[MAN_BITS-1:0]});
  assign enc_mant = src_is_int ? int_mant : fp_mant;

  // Leading zero count
  always_comb begin : lzc
    lz_cnt = '0;
    for (int i = 0; i < MANT_WIDTH; i++) begin
      if (enc_mant[i]) lz_cnt = SHAMT_WIDTH'(MANT_WIDTH - 1 - i); // Highest set bit wins
    end
  end

  assign mant_zero_o = (enc_mant == '0);
  assign mant_o      = enc_mant << lz_cnt;  // Leading one lands on the MSB

  // Subnormals count as exponent 1, then undo the normalizing shift
  assign fp_exp  = EXP_WIDTH'(int'(operand_i[MAN_BITS +: EXP_BITS]) + int'(class_i.is_subnormal)
                              - BIAS - int'(lz_cnt) + int'(SHIFT_COMP));
  assign int_exp = EXP_WIDTH'(int'(MANT_WIDTH) - 1 - int'(lz_cnt));

  assign sign_o    = src_is_int ? int_sign : operand_i[DATA_WIDTH-1];
  assign exp_o     = src_is_int ? int_exp : fp_exp;
  assign dst_exp_o = EXP_WIDTH'(int'(exp_o) + BIAS);

endmodule

`default_nettype wire

//--- hdl/cast_classify.sv
// Zero-delay decode of one binary32 pattern, integer bit patterns get classified too
`timescale 1ns/10ps
`default_nettype none

module cast_classify (
  input  logic [cast_pkg::DATA_WIDTH-1:0] operand_i,
  output cast_pkg::class_t                class_o
);

  import cast_pkg::*;

  logic [EXP_BITS-1:0] exp_field;
  logic [MAN_BITS-1:0] man_field;
  logic                exp_zero;
  logic                exp_ones;
  logic                man_zero;

  assign exp_field = operand_i[MAN_BITS +: EXP_BITS];
  assign man_field = operand_i[MAN_BITS-1:0];
  assign exp_zero  = (exp_field == '0);
  assign exp_ones  = (exp_field == '1);  // Inf or NaN
  assign man_zero  = (man_field == '0);

  assign class_o.is_zero       = exp_zero & man_zero;
  assign class_o.is_subnormal  = exp_zero & ~man_zero;
  assign class_o.is_normal     = ~exp_zero & ~exp_ones;
  assign class_o.is_inf        = exp_ones & man_zero;
  assign class_o.is_nan        = exp_ones & ~man_zero;
  assign class_o.is_signalling = class_o.is_nan & ~man_field[MAN_BITS-1]; // Quiet bit clear

  // Every known pattern falls in exactly one class
  always_comb begin : chk_class
    if (!$isunknown(operand_i)) begin
      assert final ($onehot({class_o.is_zero, class_o.is_subnormal, class_o.is_normal,
                             class_o.is_inf, class_o.is_nan}))
        else $error("cast_classify: class flags not one-hot");
    end
  end

endmodule

`default_nettype wire

//--- hdl/cast_pkg.sv
// Binary32 and 32-bit integers only, rounding modes use the RISC-V frm encoding
`default_nettype none

package cast_pkg;

  // --------------------------------------------------------------------
  // Widths and binary32 fields
  // --------------------------------------------------------------------
  localparam int unsigned DATA_WIDTH  = 32;
  localparam int unsigned EXP_BITS    = 8;
  localparam int unsigned MAN_BITS    = 23;  // Stored fraction bits
  localparam int          BIAS        = 127;
  localparam int unsigned MANT_WIDTH  = 32;  // Room for a full integer magnitude
  localparam int unsigned EXP_WIDTH   = 10;  // Signed, from -149 up past the integer range
  localparam int unsigned SHAMT_WIDTH = 5;
  localparam logic [DATA_WIDTH-1:0] QNAN = 32'h7FC0_0000;

  // Shifter geometry
  localparam int unsigned SHIFT_COMP   = MANT_WIDTH - 1 - MAN_BITS; // Float mantissa sits low
  localparam int unsigned PRE_WIDTH    = 2 * MANT_WIDTH + 1;
  localparam int unsigned DENORM_WIDTH = $clog2(MANT_WIDTH + 1);
  localparam int unsigned FP_STICKY    = 2 * MANT_WIDTH - MAN_BITS - 1; // Below fraction and R
  localparam int unsigned INT_STICKY   = 2 * MANT_WIDTH - DATA_WIDTH;   // Below integer and R

  typedef enum logic [0:0] {
    OP_I2F = 1'b0,
    OP_F2I = 1'b1
  } op_e;

  typedef enum logic [2:0] {
    RM_RNE = 3'b000,
    RM_RTZ = 3'b001,
    RM_RDN = 3'b010,
    RM_RUP = 3'b011,
    RM_RMM = 3'b100
  } round_e;

  typedef struct packed {
    logic NV;
    logic DZ;  // Never raised by a cast
    logic OF;
    logic UF;
    logic NX;
  } status_t;

  typedef struct packed {
    logic is_zero;
    logic is_subnormal;
    logic is_normal;
    logic is_inf;
    logic is_nan;
    logic is_signalling;
  } class_t;

  // Pipeline payloads
  localparam int unsigned STAGE1_WIDTH = 1 + 2 * EXP_WIDTH + MANT_WIDTH + 1 + $bits(class_t)
                                       + $bits(op_e) + 1 + $bits(round_e);
  localparam int unsigned STAGE2_WIDTH = DATA_WIDTH + $bits(status_t);

endpackage

`default_nettype wire
